// File: quant_top.f
+incdir+rtl
rtl/jpeg_coef_pkg.sv
rtl/quant_ctrl_pkg.sv
rtl/coef_block_buffer.sv
rtl/quant_sequencer.sv
rtl/pipelined_divider.sv
rtl/quant_top.sv
dv/quant_top_assert.sv
dv/quant_top_tb.sv

// File: dv/quant_top_tb.sv
`timescale 1ns/1ps

`include "quant_settings.svh"

module quant_top_tb
    import jpeg_coef_pkg::*;
();

    localparam int NUM_BLOCKS     = 16;
    // input gaps and output gaps each stretch a block to at most twice its length
    localparam int BLOCK_WORST    = 4 * `BLOCK_SIZE + `DIV_LATENCY + 8;
    localparam int TIMEOUT_CYCLES = 4 * NUM_BLOCKS * BLOCK_WORST;

    logic       clock;
    logic       nreset;
    logic       coef_in_valid_i;
    coef_in_t   coef_in_i;
    logic       coef_in_ready_o;
    logic       quant_out_valid_o;
    quant_out_t quant_out_o;
    logic       quant_out_ready_i;

    logic [15:0] lfsr;
    logic        ready_gaps;
    int          cycle_count;
    int          value_errors;
    int          index_errors;
    int          last_errors;
    int          other_errors;
    int          total_errors;
    int          model_cnt;
    blk_idx_t    zz_rm [0:`BLOCK_SIZE-1];
    coef_t       model_blk [0:`BLOCK_SIZE-1];
    quant_out_t  exp_q [$];
    quant_out_t  exp_item;

    quant_top i_quant_top (
        .clock             (clock),
        .nreset            (nreset),
        .coef_in_valid_i   (coef_in_valid_i),
        .coef_in_i         (coef_in_i),
        .coef_in_ready_o   (coef_in_ready_o),
        .quant_out_valid_o (quant_out_valid_o),
        .quant_out_o       (quant_out_o),
        .quant_out_ready_i (quant_out_ready_i)
    );

    always #50 clock = ~clock;

    ////////////////////
    // random numbers

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic coef_t extreme_coef();
        case (rand_bits(3))
            3'd0: return coef_t'(-32768);
            3'd1: return coef_t'(32767);
            3'd2: return coef_t'(1);
            3'd3: return coef_t'(-1);
            3'd4: return coef_t'(0);
            3'd5: return coef_t'(-32767);
            3'd6: return coef_t'(-15);
            default: return coef_t'(15);
        endcase
    endfunction

    ////////////////////
    // reference model

    // walk the 15 anti-diagonals, direction flips on every diagonal
    function automatic void build_zigzag();
        int k;
        int row;
        k = 0;
        for (int s = 0; s < 15; s++) begin
            for (int j = 0; j < 8; j++) begin
                row = (s % 2 == 0) ? 7 - j : j;
                if (row <= s && s - row < 8) begin
                    zz_rm[k] = blk_idx_t'(row * 8 + s - row);
                    k++;
                end
            end
        end
    endfunction

    function automatic void push_block_results();
        quant_out_t r;
        int         q;
        for (int k = 0; k < `BLOCK_SIZE; k++) begin
            // int division truncates toward zero
            q = int'(model_blk[zz_rm[k]]) / int'(QUANT_TABLE_ZZ[k]);
            r.value = coef_t'(q);
            r.index = blk_idx_t'(k);
            r.last  = (k == `BLOCK_SIZE - 1);
            exp_q.push_back(r);
        end
    endfunction

    always @(posedge clock) begin
        if (nreset) begin
            model_cnt = 0;
            exp_q.delete();
        end else if (coef_in_valid_i && coef_in_ready_o) begin
            model_blk[model_cnt] = coef_in_i.coef;
            model_cnt++;
            if (model_cnt == `BLOCK_SIZE) begin
                push_block_results();
                model_cnt = 0;
            end
        end
    end

    ////////////////////
    // checks

    task automatic check_coef(input coef_t got, input coef_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input quant_out_t got, input quant_out_t exp);
        check_coef(got.value, exp.value, $sformatf("value at index %0d", exp.index));
        if (got.index !== exp.index) begin
            index_errors++;
            $display("[FAIL] %0t: index got %0d expected %0d", $time, got.index, exp.index);
        end
        if (got.last !== exp.last) begin
            last_errors++;
            $display("[FAIL] %0t: last got %0b expected %0b", $time, got.last, exp.last);
        end
    endtask

    always @(posedge clock) begin
        if (!nreset && quant_out_valid_o && quant_out_ready_i) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("output at %0t arrived with no result pending", $time);
            end else begin
                exp_item = exp_q.pop_front();
                check_result(quant_out_o, exp_item);
            end
        end
    end

    ////////////////////
    // stimulus

    task automatic next_cycle();
        @(negedge clock);
        quant_out_ready_i = ready_gaps ? (rand_bits(2) != 2'd0) : 1'b1;
    endtask

    // ready only changes on the rising edge, so its value now holds for the next edge
    task automatic send_coef(input coef_t c, input bit in_gaps);
        bit sent;
        sent = 1'b0;
        while (!sent) begin
            next_cycle();
            if (in_gaps && rand_bits(2) == 2'd0) begin
                coef_in_valid_i = 1'b0;
            end else begin
                coef_in_valid_i = 1'b1;
                coef_in_i.coef  = c;
                sent            = coef_in_ready_o;
            end
        end
    endtask

    task automatic send_block(input int count, input bit extreme, input bit in_gaps);
        coef_t c;
        for (int i = 0; i < count; i++) begin
            c = extreme ? extreme_coef() : coef_t'(rand_bits(16));
            send_coef(c, in_gaps);
        end
    endtask

    task automatic drain();
        next_cycle();
        coef_in_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        // catch any extra result behind the last one
        repeat (`DIV_LATENCY + 4) next_cycle();
    endtask

    task automatic apply_reset();
        next_cycle();
        nreset          = 1'b1;
        coef_in_valid_i = 1'b0;
        repeat (2) next_cycle();
        nreset = 1'b0;
    endtask

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: results still missing after %0d cycles", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clock             = 1'b0;
        nreset            = 1'b1;
        coef_in_valid_i   = 1'b0;
        coef_in_i         = '0;
        quant_out_ready_i = 1'b1;
        lfsr              = 16'd77;
        ready_gaps        = 1'b0;
        cycle_count       = 0;
        value_errors      = 0;
        index_errors      = 0;
        last_errors       = 0;
        other_errors      = 0;
        model_cnt         = 0;
        build_zigzag();
        repeat (2) next_cycle();
        nreset = 1'b0;

        // one block, then eight back to back
        send_block(`BLOCK_SIZE, 1'b0, 1'b0);
        drain();
        for (int b = 0; b < 8; b++) begin
            send_block(`BLOCK_SIZE, 1'b0, 1'b0);
        end
        drain();

        // back-pressure from the output side
        ready_gaps = 1'b1;
        for (int b = 0; b < 5; b++) begin
            send_block(`BLOCK_SIZE, 1'b0, 1'b1);
        end
        drain();
        ready_gaps = 1'b0;

        send_block(`BLOCK_SIZE, 1'b1, 1'b1);
        drain();

        // partial block is thrown away by the reset
        send_block(30, 1'b0, 1'b0);
        apply_reset();
        send_block(`BLOCK_SIZE, 1'b0, 1'b0);
        drain();

        total_errors = value_errors + index_errors + last_errors + other_errors
                     + i_quant_top.i_quant_top_assert.assert_errors;
        $display("errors: value %0d, index %0d, last %0d, other %0d, assertion %0d",
                 value_errors, index_errors, last_errors, other_errors,
                 i_quant_top.i_quant_top_assert.assert_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: dv/quant_top_assert.sv
`timescale 1ns/1ps

`include "quant_settings.svh"

module quant_top_assert
    import jpeg_coef_pkg::*;
(
    input logic                  clock,
    input logic                  nreset,
    input logic                  coef_in_ready_o,
    input logic                  quant_out_valid_o,
    input quant_out_t            quant_out_o,
    input logic                  quant_out_ready_i,
    input logic [`NUM_BANKS-1:0] bank_full
);

    int assert_errors = 0;

    // a stalled result stays put until it is taken
    hold_on_stall: assert property (@(posedge clock) disable iff (nreset)
        quant_out_valid_o && !quant_out_ready_i |=> quant_out_valid_o && $stable(quant_out_o))
    else begin
        assert_errors++;
        $error("output changed while valid and not ready");
    end

    last_on_63: assert property (@(posedge clock) disable iff (nreset)
        quant_out_valid_o |-> (quant_out_o.last == (quant_out_o.index == blk_idx_t'(63))))
    else begin
        assert_errors++;
        $error("last flag does not match index 63");
    end

    // both banks are empty once reset is over
    ready_after_reset: assert property (@(posedge clock)
        nreset |=> coef_in_ready_o)
    else begin
        assert_errors++;
        $error("input not ready after reset");
    end

    stall_only_when_full: assert property (@(posedge clock) disable iff (nreset)
        !coef_in_ready_o |-> &bank_full)
    else begin
        assert_errors++;
        $error("input stalled while a bank was free");
    end

endmodule

bind quant_top quant_top_assert i_quant_top_assert (
    .clock             (clock),
    .nreset            (nreset),
    .coef_in_ready_o   (coef_in_ready_o),
    .quant_out_valid_o (quant_out_valid_o),
    .quant_out_o       (quant_out_o),
    .quant_out_ready_i (quant_out_ready_i),
    .bank_full         (bank_full)
);

// File: rtl/quant_top.sv
`timescale 1ns/1ps

`include "quant_settings.svh"

module quant_top
    import jpeg_coef_pkg::*;
    import quant_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       nreset,

    input  logic       coef_in_valid_i,
    input  coef_in_t   coef_in_i,
    output logic       coef_in_ready_o,

    output logic       quant_out_valid_o,
    output quant_out_t quant_out_o,
    input  logic       quant_out_ready_i
);

    // buffer <-> sequencer
    logic [`NUM_BANKS-1:0]  bank_full;
    logic [`NUM_BANKS-1:0]  bank_release;
    logic                   rd_en;
    logic [`BANK_SEL_W-1:0] rd_bank;
    blk_idx_t               rd_addr;
    coef_t                  rd_data;

    // sequencer <-> divider
    logic                   div_valid;
    coef_t                  dividend;
    qdiv_t                  divisor;
    div_tag_t               div_tag;
    logic                   div_stall;

    // divider output
    coef_t                  quotient;
    div_tag_t               out_tag;

    coef_block_buffer i_coef_block_buffer (
        .clock          (clock),
        .nreset         (nreset),
        .wr_valid_i     (coef_in_valid_i),
        .wr_data_i      (coef_in_i),
        .wr_ready_o     (coef_in_ready_o),
        .rd_en_i        (rd_en),
        .rd_bank_i      (rd_bank),
        .rd_addr_i      (rd_addr),
        .rd_data_o      (rd_data),
        .bank_full_o    (bank_full),
        .bank_release_i (bank_release)
    );

    quant_sequencer i_quant_sequencer (
        .clock          (clock),
        .nreset         (nreset),
        .bank_full_i    (bank_full),
        .stall_i        (div_stall),
        .rd_en_o        (rd_en),
        .rd_bank_o      (rd_bank),
        .rd_addr_o      (rd_addr),
        .rd_data_i      (rd_data),
        .bank_release_o (bank_release),
        .div_valid_o    (div_valid),
        .dividend_o     (dividend),
        .divisor_o      (divisor),
        .tag_o          (div_tag)
    );

    pipelined_divider #(
        .tag_t (div_tag_t)
    ) i_pipelined_divider (
        .clock       (clock),
        .nreset      (nreset),
        .in_valid_i  (div_valid),
        .dividend_i  (dividend),
        .divisor_i   (divisor),
        .tag_i       (div_tag),
        .stall_o     (div_stall),
        .out_valid_o (quant_out_valid_o),
        .quotient_o  (quotient),
        .tag_o       (out_tag),
        .out_ready_i (quant_out_ready_i)
    );

    // output record straight from the last divider stage
    assign quant_out_o = '{value: quotient, index: out_tag.index, last: out_tag.last};

endmodule

// File: rtl/pipelined_divider.sv
`timescale 1ns/1ps

`include "quant_settings.svh"

module pipelined_divider
    import jpeg_coef_pkg::*;
#(
    parameter type tag_t = logic
) (
    input  logic  clock,
    input  logic  nreset,

    input  logic  in_valid_i,
    input  coef_t dividend_i,
    input  qdiv_t divisor_i,
    input  tag_t  tag_i,
    output logic  stall_o,

    output logic  out_valid_o,
    output coef_t quotient_o,
    output tag_t  tag_o,
    input  logic  out_ready_i
);

    localparam int CW    = `COEF_WIDTH;
    localparam int QW    = `QDIV_WIDTH;
    // one restoring stage per quotient bit
    localparam int STEPS = `DIV_LATENCY - 2;

    // bits starts as the dividend magnitude and ends as the quotient magnitude
    typedef struct packed {
        logic          neg;
        logic [QW-1:0] rem;
        logic [CW-1:0] bits;
        qdiv_t         divisor;
        tag_t          tag;
    } stage_t;

    stage_t         st_q [0:STEPS];
    logic [STEPS:0] vld_q;
    logic           out_valid_q;
    coef_t          quotient_q;
    tag_t           tag_q;
    stage_t         first;
    logic           advance;

    // one quotient bit per call, remainder always stays below the divisor
    function automatic stage_t div_step(stage_t s);
        stage_t        n;
        logic [QW:0]   trial;
        logic [QW:0]   diff;
        n     = s;
        trial = {s.rem, s.bits[CW-1]};
        diff  = trial - {1'b0, s.divisor};
        n.bits = {s.bits[CW-2:0], 1'b0};
        if (trial >= {1'b0, s.divisor}) begin
            n.rem     = diff[QW-1:0];
            n.bits[0] = 1'b1;
        end else begin
            n.rem = trial[QW-1:0];
        end
        return n;
    endfunction

    // global enable, the whole pipe moves only when the output can drain
    assign stall_o = out_valid_q && !out_ready_i;
    assign advance = !stall_o;

    ////////////////////
    // magnitude and sign

    always_comb begin
        first.neg     = dividend_i[CW-1];
        first.rem     = '0;
        // -32768 maps to 16'h8000, read back as an unsigned magnitude
        first.bits    = first.neg ? -dividend_i : dividend_i;
        first.divisor = divisor_i;
        first.tag     = tag_i;
    end

    ////////////////////
    // datapath

    always_ff @(posedge clock) begin
        if (advance) begin
            st_q[0] <= first;
            for (int k = 0; k < STEPS; k++) begin
                st_q[k+1] <= div_step(st_q[k]);
            end
            // sign last, so the result truncates toward zero
            quotient_q <= st_q[STEPS].neg ? coef_t'(-st_q[STEPS].bits)
                                          : coef_t'(st_q[STEPS].bits);
            tag_q      <= st_q[STEPS].tag;
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            vld_q       <= '0;
            out_valid_q <= 1'b0;
        end else if (advance) begin
            vld_q       <= {vld_q[STEPS-1:0], in_valid_i};
            out_valid_q <= vld_q[STEPS];
        end
    end

    assign out_valid_o = out_valid_q;
    assign quotient_o  = quotient_q;
    assign tag_o       = tag_q;

endmodule

// File: rtl/quant_sequencer.sv
`timescale 1ns/1ps

`include "quant_settings.svh"

module quant_sequencer
    import jpeg_coef_pkg::*;
    import quant_ctrl_pkg::*;
(
    input  logic                   clock,
    input  logic                   nreset,

    input  logic [`NUM_BANKS-1:0]  bank_full_i,
    input  logic                   stall_i,

    output logic                   rd_en_o,
    output logic [`BANK_SEL_W-1:0] rd_bank_o,
    output blk_idx_t               rd_addr_o,
    input  coef_t                  rd_data_i,
    output logic [`NUM_BANKS-1:0]  bank_release_o,

    output logic                   div_valid_o,
    output coef_t                  dividend_o,
    output qdiv_t                  divisor_o,
    output div_tag_t               tag_o
);

    localparam blk_idx_t LAST_IDX = blk_idx_t'(`BLOCK_SIZE - 1);
    localparam logic [`BANK_SEL_W-1:0] LAST_BANK = `BANK_SEL_W'(`NUM_BANKS - 1);

    // zig-zag index to row-major position
    localparam blk_idx_t ZZ_TO_RM [0:`BLOCK_SIZE-1] = '{
         0,  1,  8, 16,  9,  2,  3, 10,
        17, 24, 32, 25, 18, 11,  4,  5,
        12, 19, 26, 33, 40, 48, 41, 34,
        27, 20, 13,  6,  7, 14, 21, 28,
        35, 42, 49, 56, 57, 50, 43, 36,
        29, 22, 15, 23, 30, 37, 44, 51,
        58, 59, 52, 45, 38, 31, 39, 46,
        53, 60, 61, 54, 47, 55, 62, 63
    };

    seq_state_t             state_q;
    logic [`BANK_SEL_W-1:0] bank_q;
    blk_idx_t               zz_q;
    logic                   issue;
    logic [`NUM_BANKS-1:0]  release_q;
    logic                   valid_q;
    qdiv_t                  divisor_q;
    div_tag_t               tag_q;

    ////////////////////
    // issue stage

    // one read per unstalled cycle while walking
    assign issue     = (state_q == SEQ_WALK) && !stall_i;
    assign rd_en_o   = issue;
    assign rd_bank_o = bank_q;
    assign rd_addr_o = ZZ_TO_RM[zz_q];

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q   <= SEQ_IDLE;
            bank_q    <= '0;
            zz_q      <= '0;
            release_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            release_q <= '0;

            // register stage valid, frozen together with the divider
            if (!stall_i) begin
                valid_q <= issue;
            end

            case (state_q)
                SEQ_IDLE: begin
                    zz_q <= '0;
                    // banks are taken strictly in fill order
                    if (bank_full_i[bank_q]) begin
                        state_q <= SEQ_WALK;
                    end
                end

                SEQ_WALK: begin
                    if (issue) begin
                        zz_q <= zz_q + 1'b1;
                        if (zz_q == LAST_IDX) begin
                            state_q <= SEQ_IDLE;
                            // release pulse lands the cycle after the last read
                            release_q[bank_q] <= 1'b1;
                            if (bank_q == LAST_BANK) begin
                                bank_q <= '0;
                            end else begin
                                bank_q <= bank_q + 1'b1;
                            end
                        end
                    end
                end

                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // register stage

    // table entry and tag line up with the one-cycle buffer read
    always_ff @(posedge clock) begin
        if (issue) begin
            divisor_q   <= QUANT_TABLE_ZZ[zz_q];
            tag_q.index <= zz_q;
            tag_q.last  <= (zz_q == LAST_IDX);
        end
    end

    assign bank_release_o = release_q;
    assign div_valid_o    = valid_q;
    assign dividend_o     = rd_data_i;
    assign divisor_o      = divisor_q;
    assign tag_o          = tag_q;

endmodule

// File: rtl/coef_block_buffer.sv
`timescale 1ns/1ps

`include "quant_settings.svh"

module coef_block_buffer
    import jpeg_coef_pkg::*;
(
    input  logic                   clock,
    input  logic                   nreset,

    input  logic                   wr_valid_i,
    input  coef_in_t               wr_data_i,
    output logic                   wr_ready_o,

    input  logic                   rd_en_i,
    input  logic [`BANK_SEL_W-1:0] rd_bank_i,
    input  blk_idx_t               rd_addr_i,
    output coef_t                  rd_data_o,

    output logic [`NUM_BANKS-1:0]  bank_full_o,
    input  logic [`NUM_BANKS-1:0]  bank_release_i
);

    localparam blk_idx_t LAST_ADDR = blk_idx_t'(`BLOCK_SIZE - 1);
    localparam logic [`BANK_SEL_W-1:0] LAST_BANK = `BANK_SEL_W'(`NUM_BANKS - 1);

    // both banks in one array, addressed as {bank, position}
    coef_t mem [0:`NUM_BANKS*`BLOCK_SIZE-1];

    logic [`BANK_SEL_W-1:0] fill_bank_q;
    blk_idx_t               wr_addr_q;
    logic [`NUM_BANKS-1:0]  full_q;
    logic                   wr_fire;
    logic                   block_done;

    // the bank being filled is only full again once both banks are full
    assign wr_ready_o  = !full_q[fill_bank_q];
    assign wr_fire     = wr_valid_i && wr_ready_o;
    assign block_done  = wr_fire && (wr_addr_q == LAST_ADDR);
    assign bank_full_o = full_q;

    ////////////////////
    // storage

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            mem[{fill_bank_q, wr_addr_q}] <= wr_data_i.coef;
        end
        // read data holds while no read is issued
        if (rd_en_i) begin
            rd_data_o <= mem[{rd_bank_i, rd_addr_i}];
        end
    end

    ////////////////////
    // fill and release bookkeeping

    always_ff @(posedge clock) begin
        if (nreset) begin
            fill_bank_q <= '0;
            wr_addr_q   <= '0;
            full_q      <= '0;
        end else begin
            if (wr_fire) begin
                wr_addr_q <= wr_addr_q + 1'b1;
            end

            // move on to the next bank after the 64th coefficient
            if (block_done) begin
                if (fill_bank_q == LAST_BANK) begin
                    fill_bank_q <= '0;
                end else begin
                    fill_bank_q <= fill_bank_q + 1'b1;
                end
            end

            // a bank cannot complete and be released in the same cycle
            for (int b = 0; b < `NUM_BANKS; b++) begin
                if (block_done && (fill_bank_q == `BANK_SEL_W'(b))) begin
                    full_q[b] <= 1'b1;
                end else if (bank_release_i[b]) begin
                    full_q[b] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/quant_ctrl_pkg.sv
`include "quant_settings.svh"

package quant_ctrl_pkg;

    import jpeg_coef_pkg::*;

    ////////////////////
    // sequencer

    // idle waits for the next bank in fill order to become full,
    // walk issues one zig-zag index per unstalled cycle
    typedef enum logic {
        SEQ_IDLE,
        SEQ_WALK
    } seq_state_t;

    ////////////////////
    // divider side-band

    // travels beside each dividend through every divider stage
    typedef struct packed {
        blk_idx_t index;
        // high only with index 63
        logic     last;
    } div_tag_t;

endpackage

// File: rtl/jpeg_coef_pkg.sv
`include "quant_settings.svh"

package jpeg_coef_pkg;

    ////////////////////
    // scalar types

    typedef logic signed [`COEF_WIDTH-1:0] coef_t;
    // never zero
    typedef logic [`QDIV_WIDTH-1:0]        qdiv_t;
    typedef logic [`BLOCK_ADDR_W-1:0]      blk_idx_t;

    ////////////////////
    // stream types

    // position in the block follows from arrival order (row-major)
    typedef struct packed {
        coef_t coef;
    } coef_in_t;

    typedef struct packed {
        coef_t    value;
        blk_idx_t index;
        logic     last;
    } quant_out_t;

    ////////////////////
    // luminance quantization table, zig-zag order

    localparam qdiv_t QUANT_TABLE_ZZ [0:`BLOCK_SIZE-1] = '{
        16,  11,  12,  14,  12,  10,  16,  14,
        13,  14,  18,  17,  16,  19,  24,  40,
        26,  24,  22,  22,  24,  49,  35,  37,
        29,  40,  58,  51,  61,  60,  57,  51,
        56,  55,  64,  72,  92,  78,  64,  68,
        87,  69,  55,  56,  80, 109,  81,  87,
        95,  98, 103, 104, 103,  62,  77, 113,
        121, 112, 100, 120,  92, 101, 103,  99
    };

endpackage

// File: rtl/quant_settings.svh
`ifndef QUANT_SETTINGS_SVH
`define QUANT_SETTINGS_SVH

// dct coefficient and quantized result width
`define COEF_WIDTH   16

// quantization table entry width
`define QDIV_WIDTH   8

// block geometry, one 8x8 block
`define BLOCK_SIZE   64
`define BLOCK_ADDR_W 6

// ping-pong banks and the width of a bank select
`define NUM_BANKS    2
`define BANK_SEL_W   1

// input stage, one restoring stage per quotient bit, sign stage
`define DIV_LATENCY  (`COEF_WIDTH + 2)

`endif
